//--- common/st_buf_pkg.sv
// --------------------
// Shared widths, counts and types of the store buffer.
// Imported by every store buffer module and by the entry interface.
// --------------------
`default_nettype none

package st_buf_pkg;

  // Sizes
  localparam int ST_BUF_ENTRIES = 4;
  localparam int ST_BUF_BYTES   = 8;
  localparam int DCACHE_BYTES   = 16;
  localparam int PADDR_W        = 32;
  localparam int LD_BYTES       = 4;
  localparam int MERGE_WINDOW   = 4;

  // Derived address positions and counts
  localparam int ST_BLK_LSB  = $clog2(ST_BUF_BYTES);
  localparam int DC_BLK_LSB  = $clog2(DCACHE_BYTES);
  localparam int ST_PER_DC   = DCACHE_BYTES / ST_BUF_BYTES;
  localparam int ST_SEL_W    = $clog2(ST_PER_DC);
  localparam int LD_SEL_LSB  = $clog2(LD_BYTES);
  localparam int LD_SEL_W    = $clog2(ST_BUF_BYTES / LD_BYTES);
  localparam int MERGE_CNT_W = $clog2(MERGE_WINDOW + 1);

  typedef logic [PADDR_W-1:0]          paddr_t;
  typedef logic [ST_BUF_BYTES*8-1:0]   st_data_t;
  typedef logic [ST_BUF_BYTES-1:0]     st_strb_t;
  typedef logic [DCACHE_BYTES*8-1:0]   dc_data_t;
  typedef logic [DCACHE_BYTES-1:0]     dc_be_t;
  typedef logic [LD_BYTES*8-1:0]       ld_data_t;
  typedef logic [LD_BYTES-1:0]         ld_strb_t;
  typedef logic [ST_BUF_ENTRIES-1:0]   entry_oh_t;
  typedef logic [MERGE_CNT_W-1:0]      merge_cnt_t;

  // Same-cycle answer to a committed store
  typedef enum logic [1:0] {
    ST_BUF_ALLOC,
    ST_BUF_MERGE,
    ST_BUF_FULL
  } st_buf_resp_t;

  typedef enum logic [1:0] {
    E_IDLE,
    E_MERGE,
    E_WR_REQ,
    E_WR_RESP
  } entry_state_t;

endpackage

`default_nettype wire

//--- common/st_buf_entry_if.sv
// --------------------
// Contents of one store buffer entry.
// The entry drives it; forwarding and the cache write read it.
// --------------------
`default_nettype none

interface st_buf_entry_if
  import st_buf_pkg::*;
();

  logic     valid;
  paddr_t   paddr;
  st_data_t data;
  st_strb_t strb;

  modport owner (
    output valid,
    output paddr,
    output data,
    output strb
  );

  modport reader (
    input valid,
    input paddr,
    input data,
    input strb
  );

endinterface

`default_nettype wire

//--- source/st_buf_ptr.sv
// --------------------
// One-hot allocation and drain pointers.
// The allocation pointer steps on i_alloc, the drain pointer on i_free.
// Both start at entry 0.
// --------------------
`default_nettype none

module st_buf_ptr
  import st_buf_pkg::*;
(
  input  wire       i_clk,
  input  wire       i_reset_n,
  input  wire       i_alloc,
  input  wire       i_free,
  output entry_oh_t o_in_ptr_oh,
  output entry_oh_t o_out_ptr_oh
);

  entry_oh_t r_in_ptr_oh;
  entry_oh_t r_out_ptr_oh;

  // --------------------
  // Allocation pointer
  // --------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr_oh <= entry_oh_t'(1);
    end else if (i_alloc) begin
      r_in_ptr_oh <= {r_in_ptr_oh[ST_BUF_ENTRIES-2:0], r_in_ptr_oh[ST_BUF_ENTRIES-1]};
    end
  end

  // --------------------
  // Drain pointer
  // --------------------
  // Head of the queue, moves once the head write completes
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_out_ptr_oh <= entry_oh_t'(1);
    end else if (i_free) begin
      r_out_ptr_oh <= {r_out_ptr_oh[ST_BUF_ENTRIES-2:0], r_out_ptr_oh[ST_BUF_ENTRIES-1]};
    end
  end

  assign o_in_ptr_oh  = r_in_ptr_oh;
  assign o_out_ptr_oh = r_out_ptr_oh;

endmodule

`default_nettype wire

//--- st_buf_entry/st_buf_entry.sv
// --------------------
// One store buffer entry.
// Loaded by an allocated store, then open for merges for MERGE_WINDOW
// cycles. Waits for the head position, issues one cache write and frees
// itself unless the write comes back as conflicting.
// --------------------
`default_nettype none

module st_buf_entry
  import st_buf_pkg::*;
(
  input  wire                  i_clk,
  input  wire                  i_reset_n,
  input  wire                  i_load,
  input  wire                  i_st_valid,
  input  paddr_t               i_st_paddr,
  input  st_data_t             i_st_data,
  input  st_strb_t             i_st_strb,
  input  wire                  i_is_head,
  input  wire                  i_l1d_wr_conflict,
  output logic                 o_merge_hit,
  output logic                 o_merge_block,
  output logic                 o_wr_req,
  output logic                 o_free,
  st_buf_entry_if.owner        entry
);

  entry_state_t r_state;
  merge_cnt_t   r_merge_cnt;

  paddr_t   r_paddr;
  st_data_t r_data;
  st_strb_t r_strb;

  logic     w_valid;
  logic     w_same_blk;
  st_data_t w_merged_data;

  assign w_valid = (r_state != E_IDLE);

  // Store hits this entry's 8-byte block
  assign w_same_blk = i_st_valid & w_valid &
                      (r_paddr[PADDR_W-1:ST_BLK_LSB] == i_st_paddr[PADDR_W-1:ST_BLK_LSB]);

  assign o_merge_hit   = w_same_blk & (r_state == E_MERGE);
  assign o_merge_block = w_same_blk & ((r_state == E_WR_REQ) | (r_state == E_WR_RESP));

  // Only the head may write, one request per visit to E_WR_REQ
  assign o_wr_req = (r_state == E_WR_REQ) & i_is_head;
  assign o_free   = (r_state == E_WR_RESP) & ~i_l1d_wr_conflict;

  // --------------------
  // State machine
  // --------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state     <= E_IDLE;
      r_merge_cnt <= '0;
    end else begin
      case (r_state)
        E_IDLE: begin
          if (i_load) begin
            r_state     <= E_MERGE;
            r_merge_cnt <= merge_cnt_t'(MERGE_WINDOW - 1);
          end
        end
        E_MERGE: begin
          // Window closes after its last counted cycle
          if (r_merge_cnt == '0) begin
            r_state <= E_WR_REQ;
          end else begin
            r_merge_cnt <= r_merge_cnt - 1'b1;
          end
        end
        E_WR_REQ: begin
          if (o_wr_req) begin
            r_state <= E_WR_RESP;
          end
        end
        E_WR_RESP: begin
          // Conflict sends the write out again next cycle
          r_state <= i_l1d_wr_conflict ? E_WR_REQ : E_IDLE;
        end
        default: begin
          r_state <= E_IDLE;
        end
      endcase
    end
  end

  // --------------------
  // Byte merge
  // --------------------
  always_comb begin
    w_merged_data = r_data;
    for (int b = 0; b < ST_BUF_BYTES; b++) begin
      if (i_st_strb[b]) begin
        w_merged_data[b*8 +: 8] = i_st_data[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_paddr <= i_st_paddr;
      r_data  <= i_st_data;
      r_strb  <= i_st_strb;
    end else if (o_merge_hit) begin
      r_data <= w_merged_data;
      r_strb <= r_strb | i_st_strb;
    end
  end

  assign entry.valid = w_valid;
  assign entry.paddr = r_paddr;
  assign entry.data  = r_data;
  assign entry.strb  = r_strb;

endmodule

`default_nettype wire

//--- source/st_buf_fwd.sv
// --------------------
// Store-to-load forwarding for one load port.
// Finds the valid entry that holds the load's 8-byte block and returns
// the 4-byte half picked by the load address.
// --------------------
`default_nettype none

module st_buf_fwd
  import st_buf_pkg::*;
(
  input  wire            i_fwd_valid,
  input  paddr_t         i_fwd_paddr,
  st_buf_entry_if.reader entries [ST_BUF_ENTRIES],
  output logic           o_fwd_hit,
  output ld_strb_t       o_fwd_strb,
  output ld_data_t       o_fwd_data
);

  entry_oh_t w_match;
  st_data_t  w_data [ST_BUF_ENTRIES];
  st_strb_t  w_strb [ST_BUF_ENTRIES];
  st_data_t  w_sel_data;
  st_strb_t  w_sel_strb;
  logic [LD_SEL_W-1:0] w_half;

  for (genvar e = 0; e < ST_BUF_ENTRIES; e++) begin : g_match
    assign w_match[e] = i_fwd_valid & entries[e].valid &
                        (entries[e].paddr[PADDR_W-1:ST_BLK_LSB] ==
                         i_fwd_paddr[PADDR_W-1:ST_BLK_LSB]);
    assign w_data[e]  = entries[e].data;
    assign w_strb[e]  = entries[e].strb;
  end

  // At most one entry holds a given block
  always_comb begin
    w_sel_data = '0;
    w_sel_strb = '0;
    for (int e = 0; e < ST_BUF_ENTRIES; e++) begin
      if (w_match[e]) begin
        w_sel_data = w_sel_data | w_data[e];
        w_sel_strb = w_sel_strb | w_strb[e];
      end
    end
  end

  assign w_half     = i_fwd_paddr[LD_SEL_LSB +: LD_SEL_W];
  assign o_fwd_hit  = |w_match;
  assign o_fwd_strb = w_sel_strb[w_half*LD_BYTES +: LD_BYTES];
  assign o_fwd_data = w_sel_data[w_half*LD_BYTES*8 +: LD_BYTES*8];

endmodule

`default_nettype wire

//--- source/st_buf_l1d_wr.sv
// --------------------
// Cache write formatting for the head entry.
// Aligns the address to the cache word, places the byte enables by
// address and repeats the entry data across the word.
// --------------------
`default_nettype none

module st_buf_l1d_wr
  import st_buf_pkg::*;
(
  input  entry_oh_t      i_out_ptr_oh,
  input  entry_oh_t      i_wr_req,
  st_buf_entry_if.reader entries [ST_BUF_ENTRIES],
  output logic           o_l1d_wr_valid,
  output paddr_t         o_l1d_wr_paddr,
  output dc_be_t         o_l1d_wr_be,
  output dc_data_t       o_l1d_wr_data
);

  paddr_t   w_paddr [ST_BUF_ENTRIES];
  st_data_t w_data  [ST_BUF_ENTRIES];
  st_strb_t w_strb  [ST_BUF_ENTRIES];
  paddr_t   w_sel_paddr;
  st_data_t w_sel_data;
  st_strb_t w_sel_strb;

  for (genvar e = 0; e < ST_BUF_ENTRIES; e++) begin : g_unpack
    assign w_paddr[e] = entries[e].paddr;
    assign w_data[e]  = entries[e].data;
    assign w_strb[e]  = entries[e].strb;
  end

  // --------------------
  // Head select
  // --------------------
  always_comb begin
    w_sel_paddr = '0;
    w_sel_data  = '0;
    w_sel_strb  = '0;
    for (int e = 0; e < ST_BUF_ENTRIES; e++) begin
      if (i_out_ptr_oh[e]) begin
        w_sel_paddr = w_sel_paddr | w_paddr[e];
        w_sel_data  = w_sel_data | w_data[e];
        w_sel_strb  = w_sel_strb | w_strb[e];
      end
    end
  end

  assign o_l1d_wr_valid = |(i_wr_req & i_out_ptr_oh);
  assign o_l1d_wr_paddr = {w_sel_paddr[PADDR_W-1:DC_BLK_LSB], {DC_BLK_LSB{1'b0}}};

  // Address bit 3 picks the lower or upper half of the enables
  assign o_l1d_wr_be   = dc_be_t'(w_sel_strb) <<
                         (ST_BUF_BYTES * w_sel_paddr[ST_BLK_LSB +: ST_SEL_W]);
  assign o_l1d_wr_data = {ST_PER_DC{w_sel_data}};

endmodule

`default_nettype wire

//--- source/st_buf_top.sv
// --------------------
// Store buffer top level.
// Takes committed stores, answers allocate, merge or full in the same
// cycle, drains entries in order to the L1D and forwards to one load.
// --------------------
`default_nettype none

module st_buf_top
  import st_buf_pkg::*;
(
  input  wire          i_clk,
  input  wire          i_reset_n,

  // Committed store
  input  wire          i_st_valid,
  input  paddr_t       i_st_paddr,
  input  st_data_t     i_st_data,
  input  st_strb_t     i_st_strb,
  output st_buf_resp_t o_st_resp,
  output logic         o_empty,

  // L1D write
  output logic         o_l1d_wr_valid,
  output paddr_t       o_l1d_wr_paddr,
  output dc_be_t       o_l1d_wr_be,
  output dc_data_t     o_l1d_wr_data,
  input  wire          i_l1d_wr_conflict,

  // Load forwarding
  input  wire          i_fwd_valid,
  input  paddr_t       i_fwd_paddr,
  output logic         o_fwd_hit,
  output ld_strb_t     o_fwd_strb,
  output ld_data_t     o_fwd_data
);

  entry_oh_t w_in_ptr_oh;
  entry_oh_t w_out_ptr_oh;
  entry_oh_t w_valids;
  entry_oh_t w_merge_hit;
  entry_oh_t w_merge_block;
  entry_oh_t w_wr_req;
  entry_oh_t w_free;
  logic      w_full;
  logic      w_alloc;

  st_buf_entry_if w_entry_if [ST_BUF_ENTRIES] ();

  // --------------------
  // Store response
  // --------------------
  assign w_full = &w_valids;

  always_comb begin
    if (|w_merge_hit) begin
      o_st_resp = ST_BUF_MERGE;
    end else if ((|w_merge_block) | w_full) begin
      o_st_resp = ST_BUF_FULL;
    end else begin
      o_st_resp = ST_BUF_ALLOC;
    end
  end

  assign w_alloc = i_st_valid & (o_st_resp == ST_BUF_ALLOC);
  assign o_empty = ~|w_valids;

  st_buf_ptr u_ptr (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_alloc      (w_alloc),
    .i_free       (|w_free),
    .o_in_ptr_oh  (w_in_ptr_oh),
    .o_out_ptr_oh (w_out_ptr_oh)
  );

  // --------------------
  // Entries
  // --------------------
  for (genvar e = 0; e < ST_BUF_ENTRIES; e++) begin : g_entry
    assign w_valids[e] = w_entry_if[e].valid;

    st_buf_entry u_entry (
      .i_clk             (i_clk),
      .i_reset_n         (i_reset_n),
      .i_load            (w_alloc & w_in_ptr_oh[e]),
      .i_st_valid        (i_st_valid),
      .i_st_paddr        (i_st_paddr),
      .i_st_data         (i_st_data),
      .i_st_strb         (i_st_strb),
      .i_is_head         (w_out_ptr_oh[e]),
      .i_l1d_wr_conflict (i_l1d_wr_conflict),
      .o_merge_hit       (w_merge_hit[e]),
      .o_merge_block     (w_merge_block[e]),
      .o_wr_req          (w_wr_req[e]),
      .o_free            (w_free[e]),
      .entry             (w_entry_if[e])
    );
  end

  // --------------------
  // Drain and forwarding
  // --------------------
  st_buf_l1d_wr u_l1d_wr (
    .i_out_ptr_oh   (w_out_ptr_oh),
    .i_wr_req       (w_wr_req),
    .entries        (w_entry_if),
    .o_l1d_wr_valid (o_l1d_wr_valid),
    .o_l1d_wr_paddr (o_l1d_wr_paddr),
    .o_l1d_wr_be    (o_l1d_wr_be),
    .o_l1d_wr_data  (o_l1d_wr_data)
  );

  st_buf_fwd u_fwd (
    .i_fwd_valid (i_fwd_valid),
    .i_fwd_paddr (i_fwd_paddr),
    .entries     (w_entry_if),
    .o_fwd_hit   (o_fwd_hit),
    .o_fwd_strb  (o_fwd_strb),
    .o_fwd_data  (o_fwd_data)
  );

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
// --------------------
// Clock and reset source for the store buffer testbench.
// 10 ns clock, reset held low for the first 10 cycles.
// --------------------
`default_nettype none

module tb_clk_gen (
  output logic o_clk,
  output logic o_reset_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 10;

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- verification/st_buf_assert.sv
// --------------------
// Concurrent checks on the store buffer ports.
// Bound into st_buf_top by the testbench.
// --------------------
`default_nettype none

module st_buf_assert (
  input wire i_clk,
  input wire i_reset_n,
  input wire i_wr_valid,
  input wire i_empty
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // Write request lasts one cycle, then the response cycle follows
  wr_pulse_a : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_wr_valid |=> !i_wr_valid)
    else begin
      $error("cache write request held for two cycles");
      fail_count++;
    end

  empty_no_wr_a : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_empty |-> !i_wr_valid)
    else begin
      $error("cache write request while the buffer is empty");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- verification/st_buf_tb.sv
// --------------------
// Testbench for the store buffer.
// Runs directed and random store, drain and forwarding sequences and
// compares every cycle against a queue model of the buffer.
// --------------------
`default_nettype none

module st_buf_tb
  import st_buf_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int     N_RAND    = 100;
  localparam int     N_STORES  = N_RAND + 16;
  localparam paddr_t ADDR_BASE = 32'h0000_8000;

  logic         clk;
  logic         reset_n;
  logic         st_valid;
  paddr_t       st_paddr;
  st_data_t     st_data;
  st_strb_t     st_strb;
  st_buf_resp_t st_resp;
  logic         empty;
  logic         wr_valid;
  paddr_t       wr_paddr;
  dc_be_t       wr_be;
  dc_data_t     wr_data;
  logic         wr_conflict;
  logic         fwd_valid;
  paddr_t       fwd_paddr;
  logic         fwd_hit;
  ld_strb_t     fwd_strb;
  ld_data_t     fwd_data;

  // Model queue, index 0 is the oldest entry
  paddr_t   m_paddr [ST_BUF_ENTRIES];
  st_data_t m_data  [ST_BUF_ENTRIES];
  st_strb_t m_strb  [ST_BUF_ENTRIES];
  int       m_age   [ST_BUF_ENTRIES];
  logic     m_resp  [ST_BUF_ENTRIES];
  int       m_cnt;

  logic [15:0] lfsr_state;
  logic        side_rand;
  logic        st_taken;
  int          errors;
  int          checks;
  int          tests;

  tb_clk_gen u_clk_gen (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  st_buf_top dut_i (
    .i_clk             (clk),
    .i_reset_n         (reset_n),
    .i_st_valid        (st_valid),
    .i_st_paddr        (st_paddr),
    .i_st_data         (st_data),
    .i_st_strb         (st_strb),
    .o_st_resp         (st_resp),
    .o_empty           (empty),
    .o_l1d_wr_valid    (wr_valid),
    .o_l1d_wr_paddr    (wr_paddr),
    .o_l1d_wr_be       (wr_be),
    .o_l1d_wr_data     (wr_data),
    .i_l1d_wr_conflict (wr_conflict),
    .i_fwd_valid       (fwd_valid),
    .i_fwd_paddr       (fwd_paddr),
    .o_fwd_hit         (fwd_hit),
    .o_fwd_strb        (fwd_strb),
    .o_fwd_data        (fwd_data)
  );

  bind st_buf_top st_buf_assert u_assert (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_wr_valid (o_l1d_wr_valid),
    .i_empty    (o_empty)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  function automatic int find_blk(input paddr_t a);
    int idx;
    idx = -1;
    for (int i = 0; i < m_cnt; i++) begin
      if (m_paddr[i][31:3] == a[31:3]) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  // Expected answer to a store from the model queue
  function automatic st_buf_resp_t ref_resp(input paddr_t a);
    int idx;
    idx = find_blk(a);
    if (idx >= 0) begin
      return (m_age[idx] < MERGE_WINDOW) ? ST_BUF_MERGE : ST_BUF_FULL;
    end
    return (m_cnt == ST_BUF_ENTRIES) ? ST_BUF_FULL : ST_BUF_ALLOC;
  endfunction

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_resp(input st_buf_resp_t got, input st_buf_resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: store response %s, expected %s", $time, got.name(), exp.name());
    end
  endtask

  task automatic check_empty(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: empty flag %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_wr(input logic got_v, input logic exp_v,
                          input paddr_t got_a, input paddr_t exp_a,
                          input dc_be_t got_be, input dc_be_t exp_be,
                          input dc_data_t got_d, input dc_data_t exp_d);
    checks++;
    if (got_v !== exp_v) begin
      errors++;
      $display("[FAIL] %0t ns: write valid %b, expected %b", $time, got_v, exp_v);
    end else if (exp_v && (got_a !== exp_a || got_be !== exp_be || got_d !== exp_d)) begin
      errors++;
      $display("[FAIL] %0t ns: write %h be %h data %h, expected %h be %h data %h",
               $time, got_a, got_be, got_d, exp_a, exp_be, exp_d);
    end
  endtask

  task automatic check_fwd(input logic got_h, input logic exp_h,
                           input ld_strb_t got_s, input ld_strb_t exp_s,
                           input ld_data_t got_d, input ld_data_t exp_d);
    checks++;
    if (got_h !== exp_h) begin
      errors++;
      $display("[FAIL] %0t ns: forward hit %b, expected %b", $time, got_h, exp_h);
    end else if (exp_h && (got_s !== exp_s || got_d !== exp_d)) begin
      errors++;
      $display("[FAIL] %0t ns: forward strb %h data %h, expected %h data %h",
               $time, got_s, got_d, exp_s, exp_d);
    end
  endtask

  task automatic pop_head();
    for (int i = 0; i < ST_BUF_ENTRIES - 1; i++) begin
      m_paddr[i] = m_paddr[i+1];
      m_data[i]  = m_data[i+1];
      m_strb[i]  = m_strb[i+1];
      m_age[i]   = m_age[i+1];
      m_resp[i]  = m_resp[i+1];
    end
    m_cnt--;
  endtask

  // --------------------
  // Compare and model update at each rising edge
  // --------------------
  always @(posedge clk) begin : compare_proc
    st_buf_resp_t exp_resp;
    logic         exp_wr;
    logic         exp_hit;
    ld_strb_t     exp_fs;
    ld_data_t     exp_fd;
    int           idx;
    if (!reset_n) begin
      m_cnt    = 0;
      st_taken = 1'b0;
    end else begin
      exp_resp = ref_resp(st_paddr);
      if (st_valid) begin
        check_resp(st_resp, exp_resp);
      end
      check_empty(empty, m_cnt == 0);
      // Head writes once its window closed and no write is in flight
      exp_wr = (m_cnt > 0) && (m_age[0] >= MERGE_WINDOW) && !m_resp[0];
      check_wr(wr_valid, exp_wr, wr_paddr, {m_paddr[0][31:4], 4'h0},
               wr_be, m_paddr[0][3] ? {m_strb[0], 8'h00} : {8'h00, m_strb[0]},
               wr_data, {m_data[0], m_data[0]});
      idx     = find_blk(fwd_paddr);
      exp_hit = fwd_valid && (idx >= 0);
      exp_fs  = '0;
      exp_fd  = '0;
      if (exp_hit) begin
        exp_fs = m_strb[idx][fwd_paddr[2]*4 +: 4];
        exp_fd = m_data[idx][fwd_paddr[2]*32 +: 32];
      end
      check_fwd(fwd_hit, exp_hit, fwd_strb, exp_fs, fwd_data, exp_fd);

      if (st_valid && exp_resp == ST_BUF_MERGE) begin
        idx = find_blk(st_paddr);
        for (int b = 0; b < 8; b++) begin
          if (st_strb[b]) begin
            m_data[idx][b*8 +: 8] = st_data[b*8 +: 8];
          end
        end
        m_strb[idx] = m_strb[idx] | st_strb;
      end
      if (m_cnt > 0) begin
        if (m_resp[0]) begin
          if (wr_conflict) begin
            m_resp[0] = 1'b0;
          end else begin
            pop_head();
          end
        end else if (exp_wr) begin
          m_resp[0] = 1'b1;
        end
      end
      for (int i = 0; i < m_cnt; i++) begin
        m_age[i]++;
      end
      if (st_valid && exp_resp == ST_BUF_ALLOC) begin
        m_paddr[m_cnt] = st_paddr;
        m_data[m_cnt]  = st_data;
        m_strb[m_cnt]  = st_strb;
        m_age[m_cnt]   = 0;
        m_resp[m_cnt]  = 1'b0;
        m_cnt++;
      end
      st_taken = st_valid && (exp_resp != ST_BUF_FULL);
    end
  end

  // --------------------
  // Stimulus helpers
  // --------------------
  task automatic tick();
    logic [63:0] r;
    @(negedge clk);
    if (side_rand) begin
      r = rand_bits(9);
      fwd_valid   = r[8];
      fwd_paddr   = ADDR_BASE | {26'd0, r[7:2]};
      wr_conflict = &r[1:0];
    end
  endtask

  // Hold a store until the buffer takes it
  task automatic put_store(input paddr_t a, input st_data_t d, input st_strb_t s);
    st_valid = 1'b1;
    st_paddr = a;
    st_data  = d;
    st_strb  = s;
    do begin
      tick();
    end while (!st_taken);
    st_valid = 1'b0;
  endtask

  task automatic present_store(input paddr_t a, input st_data_t d, input st_strb_t s,
                               input st_buf_resp_t exp);
    st_valid = 1'b1;
    st_paddr = a;
    #1;
    check_resp(st_resp, exp);
    put_store(a, d, s);
  endtask

  task automatic wait_empty();
    while (!empty) begin
      tick();
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("Test %0d %-12s %s", tests, name, (errors == err_before) ? "ok" : "FAILED");
  endtask

  initial begin : stim_proc
    int          e0;
    int          total;
    logic [63:0] r;
    st_data_t    d;
    st_valid    = 1'b0;
    st_paddr    = '0;
    st_data     = '0;
    st_strb     = '0;
    wr_conflict = 1'b0;
    fwd_valid   = 1'b0;
    fwd_paddr   = '0;
    lfsr_state  = 16'd76;
    side_rand   = 1'b0;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    wait (reset_n === 1'b1);

    e0 = errors;
    check_empty(empty, 1'b1);
    check_wr(wr_valid, 1'b0, '0, '0, '0, '0, '0, '0);
    present_store(ADDR_BASE + 32'h10, 64'h0123_4567_89ab_cdef, 8'hff, ST_BUF_ALLOC);
    check_empty(empty, 1'b0);
    wait_empty();
    end_test("reset_alloc", e0);

    // Three stores into one block inside the window
    e0 = errors;
    fwd_valid = 1'b1;
    fwd_paddr = ADDR_BASE + 32'h24;
    present_store(ADDR_BASE + 32'h20, 64'h1111_1111_1111_1111, 8'h0f, ST_BUF_ALLOC);
    present_store(ADDR_BASE + 32'h24, 64'h2222_2222_2222_2222, 8'hf0, ST_BUF_MERGE);
    present_store(ADDR_BASE + 32'h22, 64'h3333_3333_3333_3333, 8'h3c, ST_BUF_MERGE);
    wait_empty();
    fwd_valid = 1'b0;
    end_test("merge", e0);

    e0 = errors;
    for (int i = 0; i < ST_BUF_ENTRIES; i++) begin
      present_store(ADDR_BASE + paddr_t'(i * 8), 64'hA5A5_0000_0000_0000 + 64'(i),
                    8'hff >> i, ST_BUF_ALLOC);
    end
    present_store(ADDR_BASE + 32'h30, 64'h0f0f_0f0f_0f0f_0f0f, 8'h81, ST_BUF_FULL);
    wait_empty();
    end_test("full", e0);

    e0 = errors;
    fwd_valid = 1'b1;
    fwd_paddr = ADDR_BASE + 32'h0c;
    present_store(ADDR_BASE + 32'h08, 64'hdead_beef_0bad_f00d, 8'hcc, ST_BUF_ALLOC);
    present_store(ADDR_BASE + 32'h38, 64'h5555_aaaa_5555_aaaa, 8'h0f, ST_BUF_ALLOC);
    while (!wr_valid) begin
      tick();
    end
    tick();
    wr_conflict = 1'b1;
    tick();
    wr_conflict = 1'b0;
    // Head is waiting to write again, its block is closed
    present_store(ADDR_BASE + 32'h08, 64'h7777_7777_7777_7777, 8'h01, ST_BUF_FULL);
    wait_empty();
    fwd_valid = 1'b0;
    end_test("conflict", e0);

    e0 = errors;
    side_rand = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      d = rand_bits(64);
      r = rand_bits(15);
      put_store(ADDR_BASE | {26'd0, r[14:9]}, d, r[8:1]);
      if (r[0]) begin
        tick();
      end
    end
    side_rand   = 1'b0;
    fwd_valid   = 1'b0;
    wr_conflict = 1'b0;
    wait_empty();
    end_test("random", e0);

    tick();
    total = errors + dut_i.u_assert.fail_count;
    $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             tests, checks, errors, dut_i.u_assert.fail_count);
    if (total == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin : watchdog_proc
    #(N_STORES * (MERGE_WINDOW + 8) * 10);
    $display("Watchdog expired: the tests did not finish in time");
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
common/st_buf_pkg.sv
common/st_buf_entry_if.sv
source/st_buf_ptr.sv
st_buf_entry/st_buf_entry.sv
source/st_buf_fwd.sv
source/st_buf_l1d_wr.sv
source/st_buf_top.sv
verification/tb_clk_gen.sv
verification/st_buf_assert.sv
verification/st_buf_tb.sv
